/* src/boru_denetleyici.sv */
`timescale 1ns/10ps

module boru_denetleyici (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              dal_gecerli_i,
    input  logic              guncelle_gecerli_i,
    input  logic              guncelle_atladi_i,
    input  logic              dallanma_hata_i,
    input  dallanma_pkg::ps_t dogru_ps_i,
    input  logic              sayac_bitti_i,
    output logic              blok_aktif_o,
    output logic              sayac_baslat_o,
    output logic              sonuc_gecerli_o,
    output logic              sonuc_atladi_o,
    output logic              yonlendir_o,
    output dallanma_pkg::ps_t yonlendir_ps_o,
    output logic              bosalt_o
);

    // normal flow or flush penalty.
    typedef enum logic {
        CALIS,
        BOSALT
    } durum_t;

    durum_t durum;

    // drop strobes while flushing.
    assign blok_aktif_o   = dal_gecerli_i && (durum == CALIS);
    // penalty starts on the redirect edge.
    assign sayac_baslat_o = dallanma_hata_i && (durum == CALIS);
    assign bosalt_o       = (durum == BOSALT);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            durum <= CALIS;
        end else begin
            case (durum)
                CALIS: begin
                    if (sayac_baslat_o) begin
                        durum <= BOSALT;
                    end
                end
                // leave after the last penalty cycle.
                BOSALT: begin
                    if (sayac_bitti_i) begin
                        durum <= CALIS;
                    end
                end
                default: begin
                    durum <= CALIS;
                end
            endcase
        end
    end

    // one-cycle result and redirect pulses.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sonuc_gecerli_o <= 1'b0;
            sonuc_atladi_o  <= 1'b0;
            yonlendir_o     <= 1'b0;
            yonlendir_ps_o  <= '0;
        end else begin
            sonuc_gecerli_o <= guncelle_gecerli_i;
            sonuc_atladi_o  <= guncelle_gecerli_i && guncelle_atladi_i;
            yonlendir_o     <= dallanma_hata_i;
            // address only meaningful with the pulse.
            yonlendir_ps_o  <= dallanma_hata_i ? dogru_ps_i : '0;
        end
    end

    // redirect never comes without a result.
    yonlendir_sonuclu: assert property (@(posedge clk_i) disable iff (rst_i)
        yonlendir_o |-> sonuc_gecerli_o)
        else $error("boru_denetleyici: yonlendir_o without sonuc_gecerli_o");

    // flush holds exactly the penalty length.
    bosalt_suresi: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(bosalt_o) |-> bosalt_o [*dallanma_pkg::CEZA_CEVRIM] ##1 !bosalt_o)
        else $error("boru_denetleyici: bosalt_o length differs from CEZA_CEVRIM");

endmodule

/* src/bosaltma_sayaci.sv */
`timescale 1ns/10ps

module bosaltma_sayaci (
    input  logic clk_i,
    input  logic rst_i,
    input  logic sayac_baslat_i,
    output logic sayac_bitti_o
);

    // remaining flush cycles.
    dallanma_pkg::sayac_t sayac;

    // load on start, then count down to zero and stay.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sayac <= '0;
        end else if (sayac_baslat_i) begin
            sayac <= dallanma_pkg::CEZA_CEVRIM;
        end else if (sayac != '0) begin
            sayac <= sayac - 1'b1;
        end
    end

    // count of one is the last penalty cycle.
    assign sayac_bitti_o = (sayac == dallanma_pkg::sayac_t'(1));

endmodule

/* src/dallanma_birimi.sv */
`timescale 1ns/10ps

module dallanma_birimi (
    input  logic                   rst_i,
    input  logic                   blok_aktif_i,
    input  dallanma_pkg::dal_tur_t dal_buy_turu_i,
    input  logic                   dallanma_ongorusu_i,
    input  logic                   esit_mi_i,
    input  logic                   buyuk_mu_i,
    input  dallanma_pkg::ps_t      ps_i,
    input  dallanma_pkg::veri_t    imm_i,
    output logic                   guncelle_gecerli_o,
    output logic                   guncelle_atladi_o,
    output logic                   dallanma_hata_o,
    output dallanma_pkg::ps_t      dogru_ps_o
);

    // both candidate next pcs.
    dallanma_pkg::ps_t hedef_ps;
    dallanma_pkg::ps_t sirali_ps;

    // resolve direction from type and compare flags.
    always_comb begin
        guncelle_gecerli_o = 1'b0;
        guncelle_atladi_o  = 1'b0;
        if (blok_aktif_i) begin
            guncelle_gecerli_o = 1'b1;
            case (dal_buy_turu_i)
                dallanma_pkg::BRA_BEQ: begin
                    guncelle_atladi_o = esit_mi_i;
                end
                dallanma_pkg::BRA_BNE: begin
                    guncelle_atladi_o = !esit_mi_i;
                end
                // less than is neither equal nor greater.
                dallanma_pkg::BRA_BLT,
                dallanma_pkg::BRA_BLTU: begin
                    guncelle_atladi_o = !esit_mi_i && !buyuk_mu_i;
                end
                // signed or unsigned already picked by the comparator.
                dallanma_pkg::BRA_BGE,
                dallanma_pkg::BRA_BGEU: begin
                    guncelle_atladi_o = esit_mi_i || buyuk_mu_i;
                end
                // invalid code, no update and no result.
                default: begin
                    guncelle_gecerli_o = 1'b0;
                    guncelle_atladi_o  = 1'b0;
                end
            endcase
        end
    end

    // wrong guess on a valid branch.
    assign dallanma_hata_o = guncelle_gecerli_o &&
                             (dallanma_ongorusu_i != guncelle_atladi_o);

    // taken target is computed, not predicted.
    assign hedef_ps  = ps_i + imm_i;
    assign sirali_ps = ps_i + 32'd4;

    // where fetch must go after this branch.
    assign dogru_ps_o = guncelle_atladi_o ? hedef_ps : sirali_ps;

    // an error only ever comes from an accepted branch of a valid type.
    always_comb begin
        if (!rst_i && !$isunknown({dallanma_hata_o, guncelle_gecerli_o})) begin
            assert #0 (!dallanma_hata_o ||
                       (guncelle_gecerli_o && blok_aktif_i &&
                        (dal_buy_turu_i <= dallanma_pkg::BRA_BGEU)))
                else $error("dallanma_birimi: hata outside an accepted branch, tur=%h",
                            dal_buy_turu_i);
        end
    end

endmodule

/* src/dallanma_pkg.sv */
package dallanma_pkg;

    // program counter or branch target.
    typedef logic [31:0] ps_t;

    // register operand or sign-extended immediate.
    typedef logic [31:0] veri_t;

    // branch type code from decode.
    typedef logic [2:0] dal_tur_t;

    // branch type encodings, 110 and 111 are invalid.
    localparam dal_tur_t BRA_BEQ  = 3'b000;
    localparam dal_tur_t BRA_BNE  = 3'b001;
    localparam dal_tur_t BRA_BLT  = 3'b010;
    localparam dal_tur_t BRA_BGE  = 3'b011;
    localparam dal_tur_t BRA_BLTU = 3'b100;
    localparam dal_tur_t BRA_BGEU = 3'b101;

    // two-bit saturating predictor counter.
    // upper bit set means predict taken.
    typedef enum logic [1:0] {
        GUCLU_ATLAMAZ = 2'b00,
        ZAYIF_ATLAMAZ = 2'b01,
        ZAYIF_ATLAR   = 2'b10,
        GUCLU_ATLAR   = 2'b11
    } ongoru_t;

    // predictor index width.
    // index comes from pc bits 5..2.
    localparam int TABLO_ADRES_BIT = 4;

    // predictor table index.
    typedef logic [TABLO_ADRES_BIT-1:0] tablo_adres_t;

    // flush penalty counter.
    typedef logic [1:0] sayac_t;

    // flush cycles after a misprediction.
    localparam sayac_t CEZA_CEVRIM = 2'd2;

endpackage

/* src/dallanma_ust.sv */
`timescale 1ns/10ps

module dallanma_ust (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   dal_gecerli_i,
    input  dallanma_pkg::dal_tur_t dal_tur_i,
    input  dallanma_pkg::ps_t      ps_i,
    input  dallanma_pkg::veri_t    rs1_i,
    input  dallanma_pkg::veri_t    rs2_i,
    input  dallanma_pkg::veri_t    imm_i,
    output logic                   sonuc_gecerli_o,
    output logic                   sonuc_atladi_o,
    output logic                   yonlendir_o,
    output dallanma_pkg::ps_t      yonlendir_ps_o,
    output logic                   bosalt_o
);

    // compare flags.
    logic              esit_mi;
    logic              buyuk_mu;
    // predicted taken for the current pc.
    logic              ongoru;
    // resolution results.
    logic              guncelle_gecerli;
    logic              guncelle_atladi;
    logic              dallanma_hata;
    dallanma_pkg::ps_t dogru_ps;
    // controller handshakes.
    logic              blok_aktif;
    logic              sayac_baslat;
    logic              sayac_bitti;

    karsilastirici u_karsilastirici (
        .dal_tur_i  (dal_tur_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .esit_mi_o  (esit_mi),
        .buyuk_mu_o (buyuk_mu)
    );

    // read and update share ps_i.
    // update lands on the same edge.
    ongoru_tablosu u_ongoru_tablosu (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .oku_ps_i           (ps_i),
        .ongoru_o           (ongoru),
        .guncelle_gecerli_i (guncelle_gecerli),
        .guncelle_ps_i      (ps_i),
        .guncelle_atladi_i  (guncelle_atladi)
    );

    dallanma_birimi u_dallanma_birimi (
        .rst_i               (rst_i),
        .blok_aktif_i        (blok_aktif),
        .dal_buy_turu_i      (dal_tur_i),
        .dallanma_ongorusu_i (ongoru),
        .esit_mi_i           (esit_mi),
        .buyuk_mu_i          (buyuk_mu),
        .ps_i                (ps_i),
        .imm_i               (imm_i),
        .guncelle_gecerli_o  (guncelle_gecerli),
        .guncelle_atladi_o   (guncelle_atladi),
        .dallanma_hata_o     (dallanma_hata),
        .dogru_ps_o          (dogru_ps)
    );

    bosaltma_sayaci u_bosaltma_sayaci (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .sayac_baslat_i (sayac_baslat),
        .sayac_bitti_o  (sayac_bitti)
    );

    boru_denetleyici u_boru_denetleyici (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .dal_gecerli_i      (dal_gecerli_i),
        .guncelle_gecerli_i (guncelle_gecerli),
        .guncelle_atladi_i  (guncelle_atladi),
        .dallanma_hata_i    (dallanma_hata),
        .dogru_ps_i         (dogru_ps),
        .sayac_bitti_i      (sayac_bitti),
        .blok_aktif_o       (blok_aktif),
        .sayac_baslat_o     (sayac_baslat),
        .sonuc_gecerli_o    (sonuc_gecerli_o),
        .sonuc_atladi_o     (sonuc_atladi_o),
        .yonlendir_o        (yonlendir_o),
        .yonlendir_ps_o     (yonlendir_ps_o),
        .bosalt_o           (bosalt_o)
    );

endmodule

/* src/karsilastirici.sv */
`timescale 1ns/10ps

module karsilastirici (
    input  dallanma_pkg::dal_tur_t dal_tur_i,
    input  dallanma_pkg::veri_t    rs1_i,
    input  dallanma_pkg::veri_t    rs2_i,
    output logic                   esit_mi_o,
    output logic                   buyuk_mu_o
);

    // bltu and bgeu both have bit 2 set.
    logic isaretsiz;
    // operands widened by one bit.
    // the extra bit is the sign for signed types, zero otherwise.
    logic [$bits(dallanma_pkg::veri_t):0] genis_rs1;
    logic [$bits(dallanma_pkg::veri_t):0] genis_rs2;
    // rs2 - rs1, negative means rs1 is strictly greater.
    logic [$bits(dallanma_pkg::veri_t):0] fark;

    assign isaretsiz = dal_tur_i[2];

    // sign bit only kept in signed mode.
    assign genis_rs1 = {~isaretsiz & rs1_i[$left(rs1_i)], rs1_i};
    assign genis_rs2 = {~isaretsiz & rs2_i[$left(rs2_i)], rs2_i};

    // one subtractor serves both compare modes.
    assign fark = genis_rs2 - genis_rs1;

    assign esit_mi_o  = (rs1_i == rs2_i);
    // strict compare, equal operands give zero.
    assign buyuk_mu_o = fark[$left(fark)];

    // equal and greater are exclusive in both modes.
    always_comb begin
        if (!$isunknown({esit_mi_o, buyuk_mu_o})) begin
            assert #0 (!(esit_mi_o && buyuk_mu_o))
                else $error("karsilastirici: esit_mi and buyuk_mu both high, rs1=%h rs2=%h",
                            rs1_i, rs2_i);
        end
    end

endmodule

/* src/ongoru_tablosu.sv */
`timescale 1ns/10ps

module ongoru_tablosu (
    input  logic                clk_i,
    input  logic                rst_i,
    input  dallanma_pkg::ps_t   oku_ps_i,
    output logic                ongoru_o,
    input  logic                guncelle_gecerli_i,
    input  dallanma_pkg::ps_t   guncelle_ps_i,
    input  logic                guncelle_atladi_i
);

    // one counter per index.
    dallanma_pkg::ongoru_t sayaclar [1 << dallanma_pkg::TABLO_ADRES_BIT];

    dallanma_pkg::tablo_adres_t oku_adres;
    dallanma_pkg::tablo_adres_t guncelle_adres;
    // counter being trained and its next value.
    dallanma_pkg::ongoru_t      mevcut;
    dallanma_pkg::ongoru_t      yeni_durum;

    // word aligned pc, skip bits 1..0.
    assign oku_adres      = oku_ps_i[dallanma_pkg::TABLO_ADRES_BIT+1:2];
    assign guncelle_adres = guncelle_ps_i[dallanma_pkg::TABLO_ADRES_BIT+1:2];

    // read is combinational.
    // upper counter bit is the prediction.
    assign ongoru_o = sayaclar[oku_adres][1];

    // saturating step toward the resolved direction.
    always_comb begin
        mevcut     = sayaclar[guncelle_adres];
        yeni_durum = mevcut;
        case (mevcut)
            dallanma_pkg::GUCLU_ATLAMAZ: begin
                yeni_durum = guncelle_atladi_i ? dallanma_pkg::ZAYIF_ATLAMAZ
                                               : dallanma_pkg::GUCLU_ATLAMAZ;
            end
            dallanma_pkg::ZAYIF_ATLAMAZ: begin
                yeni_durum = guncelle_atladi_i ? dallanma_pkg::ZAYIF_ATLAR
                                               : dallanma_pkg::GUCLU_ATLAMAZ;
            end
            dallanma_pkg::ZAYIF_ATLAR: begin
                yeni_durum = guncelle_atladi_i ? dallanma_pkg::GUCLU_ATLAR
                                               : dallanma_pkg::ZAYIF_ATLAMAZ;
            end
            dallanma_pkg::GUCLU_ATLAR: begin
                yeni_durum = guncelle_atladi_i ? dallanma_pkg::GUCLU_ATLAR
                                               : dallanma_pkg::ZAYIF_ATLAR;
            end
            default: begin
                yeni_durum = dallanma_pkg::ZAYIF_ATLAMAZ;
            end
        endcase
    end

    // write at the edge of the accepted branch.
    // next branch already sees the new state.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < (1 << dallanma_pkg::TABLO_ADRES_BIT); i++) begin
                sayaclar[i] <= dallanma_pkg::ZAYIF_ATLAMAZ;
            end
        end else if (guncelle_gecerli_i) begin
            sayaclar[guncelle_adres] <= yeni_durum;
        end
    end

endmodule

/* tb.f */
src/dallanma_pkg.sv
src/karsilastirici.sv
src/ongoru_tablosu.sv
src/dallanma_birimi.sv
src/bosaltma_sayaci.sv
src/boru_denetleyici.sv
src/dallanma_ust.sv
testbench/dallanma_tb.sv

/* testbench/dallanma_stimulus.txt */
// columns: type pc rs1 rs2 imm taken, all hex
// types 6 and 7 are invalid, their taken column is unused
6 00002038 00000001 00000001 00000010 0
0 00001008 00000001 00000002 00000040 0
1 0000100c 00000005 00000005 00000040 0
2 00001010 00000001 80000000 00000040 0
4 00001014 ffffffff 00000001 00000040 0
3 00001018 80000000 00000007 00000040 0
5 0000101c 00000001 ffffffff 00000040 0
1 00002038 00000001 00000010 ffffffe0 1
0 0000103c 00000001 00000002 00000000 0
7 00002038 00000010 00000010 00000010 0
1 00002038 00000002 00000010 ffffffe0 1
1 00002038 00000003 00000010 ffffffe0 1
1 00002038 00000010 00000010 ffffffe0 0
0 0000103c 00000001 00000002 00000000 0
0 0000103c 00000003 00000004 00000000 0
1 00002038 00000010 00000010 ffffffe0 0
0 0000103c 00000001 00000002 00000000 0
6 00002038 00000010 00000010 00000010 0
1 00002038 00000004 00000010 ffffffe0 1
0 0000103c 00000001 00000002 00000000 0
0 0000103c 00000005 00000006 00000000 0
1 00002038 00000005 00000010 ffffffe0 1
0 00002038 12345678 12345678 00000100 1
2 00002038 ffffffff 00000001 00000100 1
4 00002038 00000001 80000000 00000100 1
3 00002038 00000001 ffffffff 00000100 1
5 00002038 80000000 00000007 00000100 1
3 00002038 deadbeef deadbeef 00000100 1
4 00002038 80000000 80000000 00000100 0

/* testbench/dallanma_tb.sv */
`timescale 1ns/10ps

module dallanma_tb;

    localparam int SAAT_PERIYOT = 40;

    logic                   clk_i;
    logic                   rst_i;
    logic                   dal_gecerli_i;
    dallanma_pkg::dal_tur_t dal_tur_i;
    dallanma_pkg::ps_t      ps_i;
    dallanma_pkg::veri_t    rs1_i;
    dallanma_pkg::veri_t    rs2_i;
    dallanma_pkg::veri_t    imm_i;
    logic                   sonuc_gecerli_o;
    logic                   sonuc_atladi_o;
    logic                   yonlendir_o;
    dallanma_pkg::ps_t      yonlendir_ps_o;
    logic                   bosalt_o;

    // stimulus columns, one slot per branch.
    dallanma_pkg::dal_tur_t tur_q [$];
    dallanma_pkg::ps_t      ps_q [$];
    dallanma_pkg::veri_t    rs1_q [$];
    dallanma_pkg::veri_t    rs2_q [$];
    dallanma_pkg::veri_t    imm_q [$];
    logic                   atladi_q [$];
    logic                   yuklendi;

    // reference counters and flush countdown.
    logic [1:0]        tablo [16];
    int                ceza_kalan;
    // outputs expected after the next rising edge.
    logic              bek_gecerli;
    logic              bek_atladi;
    logic              bek_yonlendir;
    dallanma_pkg::ps_t bek_ps;
    logic              bek_bosalt;
    // next edge still sees reset, every output must be zero.
    logic              bek_sifirda;
    logic              rst_sur;

    int kontrol_sayisi;
    int hata_sayisi;
    int dusen_sayisi;
    int yonlendir_sayisi;

    dallanma_ust u_dallanma_ust (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .dal_gecerli_i   (dal_gecerli_i),
        .dal_tur_i       (dal_tur_i),
        .ps_i            (ps_i),
        .rs1_i           (rs1_i),
        .rs2_i           (rs2_i),
        .imm_i           (imm_i),
        .sonuc_gecerli_o (sonuc_gecerli_o),
        .sonuc_atladi_o  (sonuc_atladi_o),
        .yonlendir_o     (yonlendir_o),
        .yonlendir_ps_o  (yonlendir_ps_o),
        .bosalt_o        (bosalt_o)
    );

    initial clk_i = 1'b0;
    always #(SAAT_PERIYOT / 2) clk_i = ~clk_i;

    // one output against its expected value.
    task automatic cikis_karsilastir(input string ad, input logic [31:0] gelen,
                                     input logic [31:0] beklenen);
        kontrol_sayisi++;
        assert (gelen === beklenen)
            else begin
                hata_sayisi++;
                $display("** Error: %s = %0h, expected %0h at %0t", ad, gelen, beklenen, $time);
            end
    endtask

    // direction from the branch table, signed or unsigned by type.
    function automatic logic kurala_gore_atladi(input logic [2:0] tur,
                                                input logic [31:0] a, input logic [31:0] b);
        logic sonuc;
        case (tur)
            3'd0: sonuc = (a == b);
            3'd1: sonuc = (a != b);
            3'd2: sonuc = ($signed(a) < $signed(b));
            3'd3: sonuc = ($signed(a) >= $signed(b));
            3'd4: sonuc = (a < b);
            default: sonuc = (a >= b);
        endcase
        return sonuc;
    endfunction

    // drive at the rising edge, check last edge's results at the falling edge.
    task automatic saat_adimi(input logic gecerli, input logic [2:0] tur, input logic [31:0] ps,
                              input logic [31:0] rs1, input logic [31:0] rs2,
                              input logic [31:0] imm, input logic atladi);
        logic [3:0] idx;
        logic       tahmin;
        logic       kabul;
        @(posedge clk_i);
        rst_i         <= rst_sur;
        dal_gecerli_i <= gecerli;
        dal_tur_i     <= tur;
        ps_i          <= ps;
        rs1_i         <= rs1;
        rs2_i         <= rs2;
        imm_i         <= imm;
        @(negedge clk_i);
        cikis_karsilastir("sonuc_gecerli_o", sonuc_gecerli_o, bek_gecerli);
        if (bek_gecerli || bek_sifirda) begin
            cikis_karsilastir("sonuc_atladi_o", sonuc_atladi_o, bek_atladi);
        end
        cikis_karsilastir("yonlendir_o", yonlendir_o, bek_yonlendir);
        if (bek_yonlendir || bek_sifirda) begin
            cikis_karsilastir("yonlendir_ps_o", yonlendir_ps_o, bek_ps);
        end
        cikis_karsilastir("bosalt_o", bosalt_o, bek_bosalt);
        // strobes inside the flush window are dropped.
        kabul = gecerli && (ceza_kalan == 0) && (tur <= dallanma_pkg::BRA_BGEU);
        if (gecerli && ceza_kalan != 0) dusen_sayisi++;
        if (ceza_kalan != 0) ceza_kalan--;
        // index is pc bits 5..2.
        idx           = ps[5:2];
        tahmin        = tablo[idx][1];
        bek_gecerli   = kabul;
        bek_atladi    = atladi;
        bek_yonlendir = kabul && (tahmin != atladi);
        bek_ps        = '0;
        if (bek_yonlendir) bek_ps = atladi ? ps + imm : ps + 32'd4;
        bek_sifirda   = rst_sur;
        // saturating step toward the resolved direction.
        if (kabul && atladi && tablo[idx] != 2'b11) tablo[idx] = tablo[idx] + 2'b01;
        if (kabul && !atladi && tablo[idx] != 2'b00) tablo[idx] = tablo[idx] - 2'b01;
        if (bek_yonlendir) begin
            ceza_kalan = dallanma_pkg::CEZA_CEVRIM;
            yonlendir_sayisi++;
        end
        bek_bosalt = (ceza_kalan != 0);
    endtask

    initial begin : ana_akis
        int               fd;
        int               adet;
        int               bosluk;
        logic [2:0]       tur;
        logic [31:0]      ps;
        logic [31:0]      rs1;
        logic [31:0]      rs2;
        logic [31:0]      imm;
        logic             atladi;
        logic [8*128-1:0] satir;
        rst_i            = 1'b1;
        dal_gecerli_i    = 1'b0;
        dal_tur_i        = '0;
        ps_i             = '0;
        rs1_i            = '0;
        rs2_i            = '0;
        imm_i            = '0;
        rst_sur          = 1'b1;
        bek_gecerli      = 1'b0;
        bek_atladi       = 1'b0;
        bek_yonlendir    = 1'b0;
        bek_ps           = '0;
        bek_bosalt       = 1'b0;
        bek_sifirda      = 1'b1;
        ceza_kalan       = 0;
        kontrol_sayisi   = 0;
        hata_sayisi      = 0;
        dusen_sayisi     = 0;
        yonlendir_sayisi = 0;
        yuklendi         = 1'b0;
        // counters start weakly not taken.
        for (int k = 0; k < 16; k++) tablo[k] = 2'b01;
        void'($urandom(32'h4278e6a4));
        fd = $fopen("testbench/dallanma_stimulus.txt", "r");
        if (fd == 0) begin
            hata_sayisi++;
            $display("could not open testbench/dallanma_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                adet = $fscanf(fd, "%h %h %h %h %h %h", tur, ps, rs1, rs2, imm, atladi);
                if (adet == 6) begin
                    tur_q.push_back(tur);
                    ps_q.push_back(ps);
                    rs1_q.push_back(rs1);
                    rs2_q.push_back(rs2);
                    imm_q.push_back(imm);
                    atladi_q.push_back(atladi);
                    // taken column must agree with the branch table.
                    if (tur <= dallanma_pkg::BRA_BGEU) begin
                        assert (kurala_gore_atladi(tur, rs1, rs2) == atladi)
                            else begin
                                hata_sayisi++;
                                $display("stimulus entry %0d has a taken bit against the rules",
                                         tur_q.size() - 1);
                            end
                    end
                end else begin
                    // comment line, skip the rest of it.
                    adet = $fgets(satir, fd);
                end
            end
            $fclose(fd);
        end
        yuklendi = 1'b1;
        // five reset edges, outputs must stay low.
        repeat (4) saat_adimi(1'b0, '0, '0, '0, '0, '0, 1'b0);
        rst_sur = 1'b0;
        saat_adimi(1'b0, '0, '0, '0, '0, '0, 1'b0);
        foreach (tur_q[n]) begin
            saat_adimi(1'b1, tur_q[n], ps_q[n], rs1_q[n], rs2_q[n], imm_q[n], atladi_q[n]);
            // short gap after a redirect, next strobe lands in the flush.
            bosluk = (ceza_kalan != 0) ? $urandom % 2 : $urandom % 3;
            repeat (bosluk) saat_adimi(1'b0, '0, '0, '0, '0, '0, 1'b0);
        end
        // drain the last result and flush.
        repeat (4) saat_adimi(1'b0, '0, '0, '0, '0, '0, 1'b0);
        $display("checks %0d, errors %0d, branches %0d, dropped %0d, redirects %0d",
                 kontrol_sayisi, hata_sayisi, tur_q.size(), dusen_sayisi, yonlendir_sayisi);
        if (hata_sayisi == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // run length bound from the number of branches.
    initial begin : bekci
        wait (yuklendi);
        #((tur_q.size() * 4 + 50) * SAAT_PERIYOT);
        $display("timeout, the run did not end within %0d clock periods",
                 tur_q.size() * 4 + 50);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
